// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module video_reg_port_tb -f video_reg_port.f -o video_reg_port_sim
	./obj_dir/video_reg_port_sim > sim.log 2>&1 || echo "TEST FAIL" >> sim.log
	cat sim.log
	! grep -q "TEST FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== rtl/boot_clear.sv ====
`timescale 1ns/1ps

module boot_clear
    import video_reg_pkg::*;
#(
    parameter int CLEAR_WORDS = 65536   // vram words to clear
) (
    input  logic  clk,
    input  logic  reset_i,
    input  logic  vgen_sel_i,
    output logic  boot_busy_o,
    output word_t boot_addr_o,
    output word_t boot_data_o,
    output logic  vgen_ena_o
);

    boot_state_e state;
    logic [16:0] fill_cnt;              // next word to hand out, 17 bits for 64K
    logic        last_out;              // all words handed to the port

    assign last_out    = (fill_cnt == 17'(CLEAR_WORDS));
    assign boot_busy_o = (state == BOOT_START) || ((state == BOOT_FILL) && !last_out);
    assign boot_addr_o = fill_cnt[15:0];
    assign boot_data_o = CLEAR_DATA;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= BOOT_START;
            fill_cnt   <= '0;
            vgen_ena_o <= 1'b0;
        end else begin
            case (state)
                BOOT_START: begin
                    fill_cnt <= fill_cnt + 17'd1;   // word 0 loaded into the port
                    state    <= BOOT_FILL;
                end
                BOOT_FILL: begin
                    if (!vgen_sel_i) begin
                        if (last_out) begin
                            state <= BOOT_DONE;     // final word written on this edge
                        end else begin
                            fill_cnt <= fill_cnt + 17'd1;
                        end
                    end
                end
                BOOT_DONE: begin
                    vgen_ena_o <= 1'b1;
                end
                default: begin
                    state <= BOOT_START;
                end
            endcase
        end
    end

endmodule

// ==== rtl/bus_sync.sv ====
`timescale 1ns/1ps

module bus_sync
    import video_reg_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     bus_cs_n_i,        // async chip select, low active
    input  logic     bus_rd_nwr_i,      // 1 read, 0 write
    input  reg_num_e bus_reg_num_i,
    input  logic     bus_bytesel_i,     // 0 even byte, 1 odd byte
    input  byte_t    bus_data_i,
    output logic     write_strobe_o,
    output logic     read_strobe_o,
    output reg_num_e reg_num_o,
    output logic     bytesel_o,
    output byte_t    bytedata_o
);

    logic [2:0] cs_n_sync;              // two sync stages plus one for edge detect
    logic [1:0] rd_nwr_sync;
    logic [1:0] bytesel_sync;
    reg_num_e   reg_num_sync [2];
    byte_t      data_sync [2];
    logic       cs_fall;

    assign cs_fall = cs_n_sync[2] & ~cs_n_sync[1];

    // two stage sync of the data path
    always_ff @(posedge clk) begin
        rd_nwr_sync  <= {rd_nwr_sync[0], bus_rd_nwr_i};
        bytesel_sync <= {bytesel_sync[0], bus_bytesel_i};
        reg_num_sync[0] <= bus_reg_num_i;
        reg_num_sync[1] <= reg_num_sync[0];
        data_sync[0] <= bus_data_i;
        data_sync[1] <= data_sync[0];
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_n_sync      <= 3'b111;   // bus idle
            write_strobe_o <= 1'b0;
            read_strobe_o  <= 1'b0;
            reg_num_o      <= AUX_ADDR;
            bytesel_o      <= 1'b0;
            bytedata_o     <= '0;
        end else begin
            cs_n_sync      <= {cs_n_sync[1:0], bus_cs_n_i};
            write_strobe_o <= cs_fall & ~rd_nwr_sync[1];
            read_strobe_o  <= cs_fall & rd_nwr_sync[1];
            if (cs_fall) begin          // hold until the next bus cycle
                reg_num_o  <= reg_num_sync[1];
                bytesel_o  <= bytesel_sync[1];
                bytedata_o <= data_sync[1];
            end
        end
    end

endmodule

// ==== rtl/mem_port.sv ====
`timescale 1ns/1ps

module mem_port
    import video_reg_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  vgen_sel_i,           // video owns the memory this cycle
    input  logic  boot_busy_i,
    input  word_t boot_addr_i,
    input  word_t boot_data_i,
    input  logic  req_vram_rd_i,
    input  logic  req_vram_wr_i,
    input  logic  req_aux_rd_i,
    input  logic  req_aux_wr_i,
    input  word_t req_addr_i,
    input  word_t req_data_i,
    input  word_t vram_data_i,
    input  word_t aux_data_i,
    output logic  mem_vram_sel_o,
    output logic  mem_aux_sel_o,
    output logic  mem_wr_o,
    output word_t mem_addr_o,
    output word_t mem_data_o,
    output logic  vram_rd_done_o,
    output logic  vram_wr_done_o,
    output word_t vram_rd_data_o,
    output word_t aux_rd_data_o
);

    logic pend_vram_rd;                 // host accesses on the port
    logic pend_vram_wr;
    logic pend_aux_rd;
    logic vram_rd_ack;                  // read data arrives next clock
    logic aux_rd_ack;
    logic any_req;
    logic slot_free;

    assign any_req   = req_vram_rd_i | req_vram_wr_i | req_aux_rd_i | req_aux_wr_i;
    assign slot_free = !vgen_sel_i || !(mem_vram_sel_o || mem_aux_sel_o);

    // completion is the edge where video lets go
    assign vram_rd_done_o = pend_vram_rd && !vgen_sel_i;
    assign vram_wr_done_o = pend_vram_wr && !vgen_sel_i;

    // address and write data
    always_ff @(posedge clk) begin
        if (boot_busy_i) begin
            if (slot_free) begin
                mem_addr_o <= boot_addr_i;
                mem_data_o <= boot_data_i;
            end
        end else if (any_req) begin
            mem_addr_o <= req_addr_i;
            mem_data_o <= req_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_vram_sel_o <= 1'b0;
            mem_aux_sel_o  <= 1'b0;
            mem_wr_o       <= 1'b0;
            pend_vram_rd   <= 1'b0;
            pend_vram_wr   <= 1'b0;
            pend_aux_rd    <= 1'b0;
            vram_rd_ack    <= 1'b0;
            aux_rd_ack     <= 1'b0;
            vram_rd_data_o <= '0;
            aux_rd_data_o  <= '0;
        end else begin
            if (vram_rd_ack) begin
                vram_rd_data_o <= vram_data_i;
            end
            if (aux_rd_ack) begin
                aux_rd_data_o <= aux_data_i;
            end
            vram_rd_ack <= 1'b0;
            aux_rd_ack  <= 1'b0;

            if (!vgen_sel_i) begin      // access taken, port is free again
                vram_rd_ack    <= pend_vram_rd;
                aux_rd_ack     <= pend_aux_rd;
                mem_vram_sel_o <= 1'b0;
                mem_aux_sel_o  <= 1'b0;
                mem_wr_o       <= 1'b0;
                pend_vram_rd   <= 1'b0;
                pend_vram_wr   <= 1'b0;
                pend_aux_rd    <= 1'b0;
            end

            if (boot_busy_i) begin
                if (slot_free) begin    // host requests are dropped during boot
                    mem_vram_sel_o <= 1'b1;
                    mem_wr_o       <= 1'b1;
                end
            end else if (any_req) begin // newest request wins
                mem_vram_sel_o <= req_vram_rd_i | req_vram_wr_i;
                mem_aux_sel_o  <= req_aux_rd_i | req_aux_wr_i;
                mem_wr_o       <= req_vram_wr_i | req_aux_wr_i;
                pend_vram_rd   <= req_vram_rd_i;
                pend_vram_wr   <= req_vram_wr_i;
                pend_aux_rd    <= req_aux_rd_i;
            end
        end
    end

endmodule

// ==== rtl/video_reg_pkg.sv ====
package video_reg_pkg;

    // width types
    typedef logic [7:0]  byte_t;        // one byte on the host bus
    typedef logic [15:0] word_t;        // register value, memory address or data word

    // host register numbers, the gaps are unused
    typedef enum logic [3:0] {
        AUX_ADDR = 4'h0,                // aux memory address, odd byte starts a read
        CONST    = 4'h1,                // constant word
        RD_ADDR  = 4'h2,                // vram read address
        WR_ADDR  = 4'h3,                // vram write address
        DATA     = 4'h4,                // vram data port
        DATA_2   = 4'h5,                // alias of the data port
        AUX_DATA = 4'h6,                // aux data port
        RD_INC   = 4'h8,                // added to rd addr per vram read
        WR_INC   = 4'h9                 // added to wr addr per vram write
    } reg_num_e;

    // vram clear after reset
    typedef enum logic [1:0] {
        BOOT_START,                     // first word goes out
        BOOT_FILL,                      // one word per free memory slot
        BOOT_DONE                       // video on
    } boot_state_e;

    // blue background, white space character
    localparam word_t CLEAR_DATA = 16'h0220;

endpackage

// ==== rtl/video_reg_port.sv ====
`timescale 1ns/1ps

module video_reg_port
    import video_reg_pkg::*;
#(
    parameter int CLEAR_WORDS = 65536
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     bus_cs_n_i,
    input  logic     bus_rd_nwr_i,
    input  reg_num_e bus_reg_num_i,
    input  logic     bus_bytesel_i,
    input  byte_t    bus_data_i,
    output byte_t    bus_data_o,
    input  logic     vgen_sel_i,        // 1 while video fetches
    output logic     vgen_ena_o,
    output logic     mem_vram_sel_o,
    output logic     mem_aux_sel_o,
    output logic     mem_wr_o,
    output word_t    mem_addr_o,
    output word_t    mem_data_o,
    input  word_t    vram_data_i,
    input  word_t    aux_data_i
);

    logic     write_strobe;
    logic     read_strobe;
    reg_num_e reg_num;
    logic     bytesel;
    byte_t    bytedata;
    logic     req_vram_rd;
    logic     req_vram_wr;
    logic     req_aux_rd;
    logic     req_aux_wr;
    word_t    req_addr;
    word_t    req_data;
    logic     vram_rd_done;
    logic     vram_wr_done;
    word_t    vram_rd_data;
    word_t    aux_rd_data;
    logic     boot_busy;
    word_t    boot_addr;
    word_t    boot_data;

    bus_sync i_bus_sync (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .write_strobe_o (write_strobe),
        .read_strobe_o  (read_strobe),
        .reg_num_o      (reg_num),
        .bytesel_o      (bytesel),
        .bytedata_o     (bytedata)
    );

    video_regs i_video_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .write_strobe_i (write_strobe),
        .read_strobe_i  (read_strobe),
        .reg_num_i      (reg_num),
        .bytesel_i      (bytesel),
        .bytedata_i     (bytedata),
        .vram_rd_done_i (vram_rd_done),
        .vram_wr_done_i (vram_wr_done),
        .vram_rd_data_i (vram_rd_data),
        .aux_rd_data_i  (aux_rd_data),
        .bus_data_o     (bus_data_o),
        .req_vram_rd_o  (req_vram_rd),
        .req_vram_wr_o  (req_vram_wr),
        .req_aux_rd_o   (req_aux_rd),
        .req_aux_wr_o   (req_aux_wr),
        .req_addr_o     (req_addr),
        .req_data_o     (req_data)
    );

    mem_port i_mem_port (
        .clk            (clk),
        .reset_i        (reset_i),
        .vgen_sel_i     (vgen_sel_i),
        .boot_busy_i    (boot_busy),
        .boot_addr_i    (boot_addr),
        .boot_data_i    (boot_data),
        .req_vram_rd_i  (req_vram_rd),
        .req_vram_wr_i  (req_vram_wr),
        .req_aux_rd_i   (req_aux_rd),
        .req_aux_wr_i   (req_aux_wr),
        .req_addr_i     (req_addr),
        .req_data_i     (req_data),
        .vram_data_i    (vram_data_i),
        .aux_data_i     (aux_data_i),
        .mem_vram_sel_o (mem_vram_sel_o),
        .mem_aux_sel_o  (mem_aux_sel_o),
        .mem_wr_o       (mem_wr_o),
        .mem_addr_o     (mem_addr_o),
        .mem_data_o     (mem_data_o),
        .vram_rd_done_o (vram_rd_done),
        .vram_wr_done_o (vram_wr_done),
        .vram_rd_data_o (vram_rd_data),
        .aux_rd_data_o  (aux_rd_data)
    );

    boot_clear #(
        .CLEAR_WORDS (CLEAR_WORDS)
    ) i_boot_clear (
        .clk         (clk),
        .reset_i     (reset_i),
        .vgen_sel_i  (vgen_sel_i),
        .boot_busy_o (boot_busy),
        .boot_addr_o (boot_addr),
        .boot_data_o (boot_data),
        .vgen_ena_o  (vgen_ena_o)
    );

endmodule

// ==== rtl/video_regs.sv ====
`timescale 1ns/1ps

module video_regs
    import video_reg_pkg::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     write_strobe_i,
    input  logic     read_strobe_i,
    input  reg_num_e reg_num_i,
    input  logic     bytesel_i,
    input  byte_t    bytedata_i,
    input  logic     vram_rd_done_i,    // vram read went through
    input  logic     vram_wr_done_i,    // vram write went through
    input  word_t    vram_rd_data_i,
    input  word_t    aux_rd_data_i,
    output byte_t    bus_data_o,
    output logic     req_vram_rd_o,
    output logic     req_vram_wr_o,
    output logic     req_aux_rd_o,
    output logic     req_aux_wr_o,
    output word_t    req_addr_o,
    output word_t    req_data_o
);

    word_t    reg_aux_addr;
    word_t    reg_const;
    word_t    reg_rd_addr;
    word_t    reg_wr_addr;
    word_t    reg_rd_inc;
    word_t    reg_wr_inc;
    byte_t    data_even;                // even byte for DATA and DATA_2
    byte_t    other_even;               // even byte for any other register
    reg_num_e other_reg;                // owner of other_even
    byte_t    even_byte;
    logic     is_data;
    logic     wr_odd;
    logic     rd_odd;

    assign is_data   = (reg_num_i == DATA) || (reg_num_i == DATA_2);
    assign wr_odd    = write_strobe_i & bytesel_i;
    assign rd_odd    = read_strobe_i & bytesel_i;
    assign even_byte = (other_reg == reg_num_i) ? other_even : 8'h00;

    // memory requests, one cycle with the strobe
    assign req_aux_rd_o  = wr_odd && (reg_num_i == AUX_ADDR);
    assign req_vram_rd_o = (wr_odd && (reg_num_i == RD_ADDR)) || (rd_odd && is_data);
    assign req_vram_wr_o = wr_odd && is_data;
    assign req_aux_wr_o  = wr_odd && (reg_num_i == AUX_DATA);
    assign req_data_o    = {(is_data ? data_even : even_byte), bytedata_i};

    always_comb begin
        case (reg_num_i)
            AUX_ADDR: req_addr_o = {reg_aux_addr[15:8], bytedata_i};
            RD_ADDR:  req_addr_o = {reg_rd_addr[15:8], bytedata_i};
            AUX_DATA: req_addr_o = reg_aux_addr;
            DATA, DATA_2: begin
                req_addr_o = read_strobe_i ? reg_rd_addr : reg_wr_addr;   // prefetch or write
            end
            default:  req_addr_o = reg_wr_addr;
        endcase
    end

    function automatic byte_t pick_byte(input word_t w, input logic sel);
        return sel ? w[7:0] : w[15:8];  // even byte is the high half
    endfunction

    // read-back follows the latched register number
    always_comb begin
        case (reg_num_i)
            AUX_ADDR:     bus_data_o = pick_byte(reg_aux_addr, bytesel_i);
            CONST:        bus_data_o = pick_byte(reg_const, bytesel_i);
            RD_ADDR:      bus_data_o = pick_byte(reg_rd_addr, bytesel_i);
            WR_ADDR:      bus_data_o = pick_byte(reg_wr_addr, bytesel_i);
            DATA, DATA_2: bus_data_o = pick_byte(vram_rd_data_i, bytesel_i);
            AUX_DATA:     bus_data_o = pick_byte(aux_rd_data_i, bytesel_i);
            default:      bus_data_o = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_aux_addr <= '0;
            reg_const    <= '0;
            reg_rd_addr  <= '0;
            reg_wr_addr  <= '0;
            reg_rd_inc   <= '0;
            reg_wr_inc   <= '0;
            data_even    <= '0;
            other_even   <= '0;
            other_reg    <= AUX_ADDR;
        end else begin
            if (vram_rd_done_i) begin
                reg_rd_addr <= reg_rd_addr + reg_rd_inc;
            end
            if (vram_wr_done_i) begin
                reg_wr_addr <= reg_wr_addr + reg_wr_inc;
            end

            if (write_strobe_i && !bytesel_i) begin
                case (reg_num_i)
                    AUX_ADDR:     reg_aux_addr[15:8] <= bytedata_i;
                    CONST:        reg_const[15:8]    <= bytedata_i;
                    RD_ADDR:      reg_rd_addr[15:8]  <= bytedata_i;
                    WR_ADDR:      reg_wr_addr[15:8]  <= bytedata_i;
                    DATA, DATA_2: data_even          <= bytedata_i;
                    default: begin
                        other_even <= bytedata_i;   // tagged general latch
                        other_reg  <= reg_num_i;
                    end
                endcase
            end

            if (wr_odd) begin
                other_even <= 8'h00;    // even byte is used up by any odd write
                case (reg_num_i)
                    AUX_ADDR: reg_aux_addr[7:0] <= bytedata_i;
                    CONST:    reg_const[7:0]    <= bytedata_i;
                    RD_ADDR:  reg_rd_addr[7:0]  <= bytedata_i;
                    WR_ADDR:  reg_wr_addr[7:0]  <= bytedata_i;
                    RD_INC:   reg_rd_inc        <= {even_byte, bytedata_i};
                    WR_INC:   reg_wr_inc        <= {even_byte, bytedata_i};
                    default: ;                  // data ports only request
                endcase
            end
        end
    end

endmodule

// ==== verification/mem_port_properties.sv ====
`timescale 1ns/1ps

module mem_port_properties (
    input logic clk,
    input logic reset_i,
    input logic vram_sel_i,
    input logic aux_sel_i,
    input logic wr_i
);

    // one memory at a time
    sel_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(vram_sel_i && aux_sel_i))
        else $error("vram and aux selected together");

    wr_needs_sel: assert property (@(posedge clk) disable iff (reset_i)
        wr_i |-> (vram_sel_i || aux_sel_i))
        else $error("write strobe without a memory select");

    // sync reset clears the port on its first edge
    reset_idle: assert property (@(posedge clk)
        reset_i |=> (!vram_sel_i && !aux_sel_i && !wr_i))
        else $error("memory port active during reset");

endmodule

bind mem_port mem_port_properties i_mem_port_properties (
    .clk        (clk),
    .reset_i    (reset_i),
    .vram_sel_i (mem_vram_sel_o),
    .aux_sel_i  (mem_aux_sel_o),
    .wr_i       (mem_wr_o)
);

// ==== verification/video_reg_port_tb.sv ====
`timescale 1ns/1ps

module video_reg_port_tb
    import video_reg_pkg::*;
();

    localparam int          CLEAR_WORDS = 64;
    localparam int          MEM_WORDS   = 4096;
    localparam logic [15:0] CLEAR_WORD  = 16'h0220;  // blue background, white space

    typedef struct packed {
        logic       rd;                 // 1 read, 0 write
        logic [3:0] reg_num;
        logic       bytesel;            // 0 even byte, 1 odd byte
        logic [7:0] data;
        logic [7:0] expected;           // only for reads
    } row_t;

    logic     clk = 1'b0;
    logic     reset_i;
    logic     bus_cs_n_i;
    logic     bus_rd_nwr_i;
    reg_num_e bus_reg_num_i;
    logic     bus_bytesel_i;
    byte_t    bus_data_i;
    byte_t    bus_data_o;
    logic     vgen_sel_i = 1'b0;
    logic     vgen_ena_o;
    logic     mem_vram_sel_o;
    logic     mem_aux_sel_o;
    logic     mem_wr_o;
    word_t    mem_addr_o;
    word_t    mem_data_o;
    word_t    vram_data_i = '0;
    word_t    aux_data_i = '0;

    logic [15:0] vram [MEM_WORDS];
    logic [15:0] aux [MEM_WORDS];
    row_t        stim [$];
    integer      seed = 1316;

    video_reg_port #(
        .CLEAR_WORDS (CLEAR_WORDS)
    ) i_dut (.*);

    always #20 clk = ~clk;

    // video takes about one slot in four
    always @(negedge clk) begin
        vgen_sel_i = (($random(seed) & 3) == 0);
    end

    function automatic logic [15:0] vram_fill(input int addr);
        return 16'(addr) ^ 16'h5A00;
    endfunction

    function automatic logic [15:0] aux_fill(input int addr);
        return 16'(addr) ^ 16'hC300;
    endfunction

    // shared memories, busy for the host while vgen_sel_i is high
    always @(posedge clk) begin
        if (reset_i) begin
            for (int a = CLEAR_WORDS; a < MEM_WORDS; a++) begin
                vram[12'(a)] = vram_fill(a);    // cleared range starts unknown
            end
            for (int a = 0; a < MEM_WORDS; a++) begin
                aux[12'(a)] = aux_fill(a);
            end
        end else if (!vgen_sel_i) begin
            if (mem_vram_sel_o) begin
                vram_data_i <= vram[mem_addr_o[11:0]];
                if (mem_wr_o) begin
                    vram[mem_addr_o[11:0]] = mem_data_o;
                end
            end
            if (mem_aux_sel_o) begin
                aux_data_i <= aux[mem_addr_o[11:0]];
                if (mem_wr_o) begin
                    aux[mem_addr_o[11:0]] = mem_data_o;
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic add_row(input logic rd, input logic [3:0] reg_num, input logic sel,
                           input byte_t data, input byte_t expected);
        row_t row;
        row.rd       = rd;
        row.reg_num  = reg_num;
        row.bytesel  = sel;
        row.data     = data;
        row.expected = expected;
        stim.push_back(row);
    endtask

    // even byte first, it is the high half
    task automatic add_write(input logic [3:0] reg_num, input word_t value);
        add_row(1'b0, reg_num, 1'b0, value[15:8], 8'h00);
        add_row(1'b0, reg_num, 1'b1, value[7:0], 8'h00);
    endtask

    task automatic add_read(input logic [3:0] reg_num, input word_t value);
        add_row(1'b1, reg_num, 1'b0, 8'h00, value[15:8]);
        add_row(1'b1, reg_num, 1'b1, 8'h00, value[7:0]);
    endtask

    task automatic build_table();
        add_write(AUX_ADDR, 16'h1234);
        add_write(CONST, 16'hBEEF);
        add_write(RD_ADDR, 16'h0456);
        add_write(WR_ADDR, 16'h0789);
        add_read(AUX_ADDR, 16'h1234);
        add_read(CONST, 16'hBEEF);
        add_read(RD_ADDR, 16'h0456);
        add_read(WR_ADDR, 16'h0789);
        add_read(4'h7, 16'h0000);                   // unused number
        // vram reads, each odd read fetches the next word
        add_write(RD_INC, 16'h0001);
        add_write(RD_ADDR, 16'h0100);
        add_read(DATA, vram_fill(32'h100));
        add_read(DATA_2, vram_fill(32'h101));
        add_read(DATA, vram_fill(32'h102));
        add_read(RD_ADDR, 16'h0104);
        // vram writes with stride 2
        add_write(WR_INC, 16'h0002);
        add_write(WR_ADDR, 16'h0100);
        add_write(DATA, 16'h1122);
        add_write(DATA_2, 16'h3344);
        add_write(DATA, 16'h5566);
        add_read(WR_ADDR, 16'h0106);
        // aux writes with and without a paired even byte
        add_write(AUX_ADDR, 16'h0010);
        add_write(AUX_DATA, 16'hABCD);
        add_write(AUX_ADDR, 16'h0011);
        add_row(1'b0, 4'h7, 1'b0, 8'h55, 8'h00);   // tagged for another register
        add_row(1'b0, AUX_DATA, 1'b1, 8'h77, 8'h00);
        add_write(AUX_ADDR, 16'h0010);
        add_read(AUX_DATA, 16'hABCD);
        add_write(AUX_ADDR, 16'h0011);
        add_read(AUX_DATA, 16'h0077);
        add_write(AUX_ADDR, 16'h0020);
        add_read(AUX_DATA, aux_fill(32'h20));
    endtask

    task automatic run_cycle(input row_t row);
        bus_rd_nwr_i  = row.rd;
        bus_reg_num_i = reg_num_e'(row.reg_num);
        bus_bytesel_i = row.bytesel;
        bus_data_i    = row.data;
        bus_cs_n_i    = 1'b0;
        repeat (4) @(negedge clk);              // strobe is in, prefetch not back yet
        if (row.rd) begin
            check_value($sformatf("bus_data_o (reg %0d byte %0d)", row.reg_num, row.bytesel),
                        {8'h00, bus_data_o}, {8'h00, row.expected});
        end
        repeat (2) @(negedge clk);
        bus_cs_n_i = 1'b1;
        repeat (6) @(negedge clk);
    endtask

    initial begin
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b0;
        bus_reg_num_i = AUX_ADDR;
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        build_table();
        repeat (8) @(negedge clk);
        reset_i = 1'b0;
        while (!vgen_ena_o) begin
            @(negedge clk);
        end

        for (int a = 0; a < CLEAR_WORDS; a++) begin
            check_value($sformatf("vram[0x%0h]", a), vram[12'(a)], CLEAR_WORD);
        end
        check_value("vram[0x40]", vram[12'(CLEAR_WORDS)], vram_fill(CLEAR_WORDS));

        foreach (stim[i]) begin
            run_cycle(stim[i]);
        end

        check_value("vram[0x100]", vram[12'h100], 16'h1122);
        check_value("vram[0x101]", vram[12'h101], vram_fill(32'h101));
        check_value("vram[0x102]", vram[12'h102], 16'h3344);
        check_value("vram[0x104]", vram[12'h104], 16'h5566);
        check_value("aux[0x10]", aux[12'h010], 16'hABCD);
        check_value("aux[0x11]", aux[12'h011], 16'h0077);
        check_value("vgen_ena_o", {15'd0, vgen_ena_o}, 16'h0001);

        $display("TEST PASS");
        $finish;
    end

    // boot fill plus every bus cycle, with margin for video stalls
    initial begin
        @(negedge reset_i);
        repeat ((CLEAR_WORDS + stim.size() * 16) * 2) @(posedge clk);
        $display("timeout: the test did not finish in time");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== video_reg_port.f ====
rtl/video_reg_pkg.sv
rtl/bus_sync.sv
rtl/video_regs.sv
rtl/mem_port.sv
rtl/boot_clear.sv
rtl/video_reg_port.sv
verification/mem_port_properties.sv
verification/video_reg_port_tb.sv
